//--- source/crypto_pkg.sv
// Shared widths, round count, mix-mode codes and default parameter values
// for the toy cipher controller and its trojan
package crypto_pkg;

    // Block and key width
    localparam int block_w = 128;

    // Rounds per block; the counter must also hold the terminal count
    localparam int crypto_rounds = 16;
    localparam int round_w = 5;

    // Mix step selection
    localparam logic [1:0] mode_xor = 2'd0; // XOR with trojan word
    localparam logic [1:0] mode_rot = 2'd1; // Rotate left by one
    localparam logic [1:0] mode_add = 2'd2; // Add trojan word
    localparam logic [1:0] mode_inv = 2'd3; // Bitwise invert

    // Round key derivation word
    localparam logic [31:0] default_pattern = 32'h9ABCDEF0;

    // Key byte that arms the trojan
    localparam logic [7:0] default_trigger_key = 8'hA5;

endpackage

//--- source/key_expander.sv
// Key register and round key selection from the replicated pattern word
`timescale 1ns/1ps

module key_expander #(
    parameter logic [31:0] pattern = crypto_pkg::default_pattern
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                load,
    input  logic [crypto_pkg::block_w-1:0]      key,
    input  logic [crypto_pkg::round_w-1:0]      round,
    output logic [crypto_pkg::block_w-1:0]      round_key,
    output logic [crypto_pkg::block_w-1:0]      last_key,
    output logic [7:0]                          key_low
);

    localparam logic [crypto_pkg::block_w-1:0] pattern_word = {4{pattern}};

    logic [crypto_pkg::block_w-1:0] key_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            key_q <= '0;
        end else if (load) begin
            key_q <= key; // Captured on the accepting edge
        end
    end

    // Round i uses the pattern word shifted right by 8*i bits
    assign round_key = key_q ^ (pattern_word >> {round, 3'b000});
    assign last_key  = key_q ^ (pattern_word >> ((crypto_pkg::crypto_rounds - 1) * 8));

    // While a start is being accepted the trojan must see the incoming key,
    // so the low byte bypasses the register for that one cycle
    assign key_low = load ? key[7:0] : key_q[7:0];

endmodule

//--- source/sbox_unit.sv
// Byte substitution, table on the low nibble folded with the high nibble
`timescale 1ns/1ps

module sbox_unit (
    input  logic [7:0] sbox_in,
    output logic [7:0] sbox_out
);

    logic [7:0] table_out;

    // First row of the AES S-box, indexed by the low nibble only
    always_comb begin
        case (sbox_in[3:0])
            4'h0: table_out = 8'h63;
            4'h1: table_out = 8'h7C;
            4'h2: table_out = 8'h77;
            4'h3: table_out = 8'h7B;
            4'h4: table_out = 8'hF2;
            4'h5: table_out = 8'h6B;
            4'h6: table_out = 8'h6F;
            4'h7: table_out = 8'hC5;
            4'h8: table_out = 8'h30;
            4'h9: table_out = 8'h01;
            4'hA: table_out = 8'h67;
            4'hB: table_out = 8'h2B;
            4'hC: table_out = 8'hFE;
            4'hD: table_out = 8'hD7;
            4'hE: table_out = 8'hAB;
            default: table_out = 8'h76;
        endcase
    end

    assign sbox_out = table_out ^ {4'h0, sbox_in[7:4]}; // High nibble fold

endmodule

//--- source/trojan9_payload.sv
// Trojan trigger on the key byte and the leak word it injects
`timescale 1ns/1ps

module trojan9_payload #(
    parameter logic [7:0] trigger_key = crypto_pkg::default_trigger_key
) (
    input  logic [7:0]                      state_byte,
    input  logic [7:0]                      key_byte,
    input  logic [crypto_pkg::round_w-1:0]  round,
    input  logic [1:0]                      mode,
    output logic [15:0]                     leak
);

    logic                           armed;
    logic [7:0]                     secret_mix;
    logic [crypto_pkg::round_w-1:0] tag;

    assign armed = (key_byte == trigger_key);

    // High byte leaks state and key together
    assign secret_mix = state_byte ^ key_byte;

    // Low byte marks where in the run the leak happened
    assign tag = round ^ {{(crypto_pkg::round_w - 2){1'b0}}, mode};

    assign leak = armed ? {secret_mix, {(8 - crypto_pkg::round_w){1'b0}}, tag} : 16'h0000;

endmodule

//--- source/crypto_round_ctrl.sv
// Round FSM of the toy cipher: state register, S-box step, mode mix,
// final key addition and done pulse
`timescale 1ns/1ps

module crypto_round_ctrl (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                start,
    input  logic [crypto_pkg::block_w-1:0]      plaintext,
    input  logic [1:0]                          mode,
    input  logic [crypto_pkg::block_w-1:0]      round_key,
    input  logic [crypto_pkg::block_w-1:0]      last_key,
    input  logic [7:0]                          sbox_out,
    input  logic [15:0]                         leak,
    output logic                                load,
    output logic [crypto_pkg::round_w-1:0]      round,
    output logic [7:0]                          sbox_in,
    output logic [7:0]                          state_byte,
    output logic [1:0]                          latched_mode,
    output logic [crypto_pkg::block_w-1:0]      ciphertext,
    output logic                                busy,
    output logic                                done
);

    localparam logic [2:0] st_idle    = 3'd0;
    localparam logic [2:0] st_add_key = 3'd1;
    localparam logic [2:0] st_sub     = 3'd2;
    localparam logic [2:0] st_shift   = 3'd3;
    localparam logic [2:0] st_mix     = 3'd4;
    localparam logic [2:0] st_final   = 3'd5;

    localparam logic [crypto_pkg::round_w-1:0] last_round =
        crypto_pkg::round_w'(crypto_pkg::crypto_rounds);

    logic [2:0]                         fsm_q;
    logic [crypto_pkg::round_w-1:0]     round_q;
    logic [1:0]                         mode_q;
    logic [crypto_pkg::block_w-1:0]     state_q;
    logic [crypto_pkg::block_w-1:0]     leak_ext;
    logic                               idle;

    assign idle     = (fsm_q == st_idle);
    assign load     = start && idle;
    assign busy     = !idle;
    assign round    = round_q;
    assign leak_ext = {{(crypto_pkg::block_w - 16){1'b0}}, leak};

    // In IDLE the trojan looks at the request being accepted
    assign state_byte   = idle ? plaintext[7:0] : state_q[7:0];
    assign latched_mode = idle ? mode : mode_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fsm_q      <= st_idle;
            round_q    <= '0;
            mode_q     <= crypto_pkg::mode_xor;
            ciphertext <= '0;
            done       <= 1'b0;
        end else begin
            done <= 1'b0;
            case (fsm_q)
                st_idle: begin
                    if (load) begin
                        mode_q <= mode;
                        fsm_q  <= st_add_key;
                    end
                end
                st_add_key: begin
                    if (round_q < last_round) begin
                        fsm_q <= st_sub;
                    end else begin
                        fsm_q <= st_final;
                    end
                end
                st_sub:   fsm_q <= st_shift;
                st_shift: fsm_q <= st_mix;
                st_mix: begin
                    round_q <= round_q + 1'b1;
                    fsm_q   <= st_add_key;
                end
                st_final: begin
                    ciphertext <= state_q ^ last_key;
                    done       <= 1'b1;
                    round_q    <= '0; // Trojan sees round 0 at the next start
                    fsm_q      <= st_idle;
                end
                default: fsm_q <= st_idle;
            endcase
        end
    end

    // Datapath follows the FSM
    always_ff @(posedge clk) begin
        case (fsm_q)
            st_idle: begin
                if (load) begin
                    state_q <= plaintext ^ leak_ext;
                end
            end
            st_add_key: begin
                if (round_q < last_round) begin
                    state_q <= state_q ^ round_key;
                end
            end
            st_sub: sbox_in <= state_q[7:0];
            st_shift: state_q[7:0] <= sbox_out ^ leak[7:0]; // Substituted byte plus leak
            st_mix: begin
                case (mode_q)
                    crypto_pkg::mode_xor: state_q <= state_q ^ leak_ext;
                    crypto_pkg::mode_rot: begin
                        state_q <= {state_q[crypto_pkg::block_w-2:0],
                                    state_q[crypto_pkg::block_w-1]};
                    end
                    crypto_pkg::mode_add: state_q <= state_q + leak_ext;
                    default: state_q <= ~state_q;
                endcase
            end
            default: ;
        endcase
    end

    // Done is a single-cycle pulse
    assert property (@(posedge clk) disable iff (rst) done |=> !done);

    // Counter stops at the terminal round
    assert property (@(posedge clk) disable iff (rst) round_q <= last_round);

    // A start during a run leaves the latched request alone
    assert property (@(posedge clk) disable iff (rst)
        (start && busy) |=> $stable(mode_q));

endmodule

//--- source/crypto_host_top.sv
// Cipher subsystem top: round controller, key expander, S-box and trojan
`timescale 1ns/1ps

module crypto_host_top #(
    parameter logic [31:0] pattern     = crypto_pkg::default_pattern,
    parameter logic [7:0]  trigger_key = crypto_pkg::default_trigger_key
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                start,
    input  logic [crypto_pkg::block_w-1:0]      plaintext,
    input  logic [crypto_pkg::block_w-1:0]      key,
    input  logic [1:0]                          mode,
    output logic [crypto_pkg::block_w-1:0]      ciphertext,
    output logic                                busy,
    output logic                                done
);

    logic                               load;
    logic [crypto_pkg::round_w-1:0]     round;
    logic [crypto_pkg::block_w-1:0]     round_key;
    logic [crypto_pkg::block_w-1:0]     last_key;
    logic [7:0]                         key_low;
    logic [7:0]                         sbox_in;
    logic [7:0]                         sbox_out;
    logic [7:0]                         state_byte;
    logic [1:0]                         latched_mode;
    logic [15:0]                        leak;

    crypto_round_ctrl ctrl_inst (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .plaintext    (plaintext),
        .mode         (mode),
        .round_key    (round_key),
        .last_key     (last_key),
        .sbox_out     (sbox_out),
        .leak         (leak),
        .load         (load),
        .round        (round),
        .sbox_in      (sbox_in),
        .state_byte   (state_byte),
        .latched_mode (latched_mode),
        .ciphertext   (ciphertext),
        .busy         (busy),
        .done         (done)
    );

    key_expander #(
        .pattern (pattern)
    ) key_inst (
        .clk       (clk),
        .rst       (rst),
        .load      (load),
        .key       (key),
        .round     (round),
        .round_key (round_key),
        .last_key  (last_key),
        .key_low   (key_low)
    );

    sbox_unit sbox_inst (
        .sbox_in  (sbox_in),
        .sbox_out (sbox_out)
    );

    // Planted trojan armed by the key's low byte
    trojan9_payload #(
        .trigger_key (trigger_key)
    ) trojan_inst (
        .state_byte (state_byte),
        .key_byte   (key_low),
        .round      (round),
        .mode       (latched_mode),
        .leak       (leak)
    );

endmodule

//--- tests/crypto_vectors.svh
// Stimulus table for the cipher testbench and a reference model of the
// cipher with its trojan leak
`ifndef CRYPTO_VECTORS_SVH
`define CRYPTO_VECTORS_SVH

typedef struct packed {
    logic [1:0] mode;        // Mix step
    logic       trigger;     // Key low byte forced to the trojan trigger
    logic       extra_start; // Second start pulsed mid-run
    int         latency;     // Edges from the accepting edge to done
} vec_row_t;

localparam int num_vectors = 10;

localparam vec_row_t vec_table [num_vectors] = '{
    '{2'd0, 1'b0, 1'b0, 66},
    '{2'd1, 1'b0, 1'b0, 66},
    '{2'd2, 1'b0, 1'b0, 66},
    '{2'd3, 1'b0, 1'b0, 66},
    '{2'd0, 1'b1, 1'b0, 66},
    '{2'd1, 1'b1, 1'b0, 66},
    '{2'd2, 1'b1, 1'b0, 66},
    '{2'd3, 1'b1, 1'b0, 66},
    '{2'd2, 1'b0, 1'b1, 66},
    '{2'd0, 1'b1, 1'b1, 66}
};

// Row zero of the AES S-box with one entry per nibble value
function automatic logic [7:0] sbox_entry(input logic [3:0] idx);
    logic [7:0] row [16];
    row = '{8'h63, 8'h7C, 8'h77, 8'h7B, 8'hF2, 8'h6B, 8'h6F, 8'hC5,
            8'h30, 8'h01, 8'h67, 8'h2B, 8'hFE, 8'hD7, 8'hAB, 8'h76};
    return row[idx];
endfunction

// Leak word stays zero unless the key byte matches the trigger
function automatic logic [15:0] trojan_word(input logic [7:0] sb, input logic [7:0] kb,
                                            input int r, input logic [1:0] m);
    logic [4:0] tag;
    tag = r[4:0] ^ {3'b000, m};
    if (kb != crypto_pkg::default_trigger_key) begin
        return 16'h0000;
    end
    return {sb ^ kb, 3'b000, tag};
endfunction

function automatic logic [127:0] cipher_model(input logic [127:0] pt, input logic [127:0] key,
                                              input logic [1:0] m);
    logic [127:0] w;
    logic [127:0] s;
    logic [15:0]  t;
    logic [7:0]   b;
    w = {4{crypto_pkg::default_pattern}};
    t = trojan_word(pt[7:0], key[7:0], 0, m);
    s = pt ^ {112'b0, t};
    for (int r = 0; r < 16; r++) begin
        s = s ^ key ^ (w >> (8 * r));
        b = s[7:0];
        t = trojan_word(b, key[7:0], r, m);
        s[7:0] = sbox_entry(b[3:0]) ^ {4'h0, b[7:4]} ^ t[7:0];
        t = trojan_word(s[7:0], key[7:0], r, m); // Leak sees the substituted byte
        case (m)
            2'd0: s = s ^ {112'b0, t};
            2'd1: s = {s[126:0], s[127]};
            2'd2: s = s + {112'b0, t};
            default: s = ~s;
        endcase
    end
    return s ^ key ^ (w >> 120);
endfunction

`endif

//--- tests/crypto_host_tb.sv
// Testbench for the cipher subsystem, table rows checked against the model
`timescale 1ns/1ps

module crypto_host_tb;

    `include "crypto_vectors.svh"

    localparam int cycle_limit = 16 + num_vectors * 80;

    logic         clk;
    logic         rst;
    logic         start;
    logic [127:0] plaintext;
    logic [127:0] key;
    logic [1:0]   mode;
    logic [127:0] ciphertext;
    logic         busy;
    logic         done;
    logic [31:0]  lcg_state;
    int           cycles = 0;

    crypto_host_top crypto_host_top_inst (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .plaintext  (plaintext),
        .key        (key),
        .mode       (mode),
        .ciphertext (ciphertext),
        .busy       (busy),
        .done       (done)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("=== FAIL ===");
            $fatal(1);
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic draw_block(output logic [127:0] blk);
        for (int i = 0; i < 4; i++) begin
            lcg_state = lcg_next(lcg_state);
            blk[32*i +: 32] = lcg_state;
        end
    endtask

    task automatic report_error(input string msg);
        $display("ERR %0t: %s", $time, msg);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    initial begin
        logic [127:0] pt;
        logic [127:0] k;
        logic [127:0] pt2;
        logic [127:0] k2;
        logic [127:0] expected;
        logic [127:0] held_ct;
        int           edges;
        clk = 1'b0;
        rst = 1'b1;
        start = 1'b0;
        plaintext = '0;
        key = '0;
        mode = 2'd0;
        lcg_state = 32'h5a0f;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        assert (ciphertext == '0 && !busy && !done)
            else report_error("outputs not idle after reset");
        held_ct = '0;
        for (int i = 0; i < num_vectors; i++) begin
            draw_block(pt);
            draw_block(k);
            if (vec_table[i].trigger) begin
                k[7:0] = crypto_pkg::default_trigger_key;
            end else if (k[7:0] == crypto_pkg::default_trigger_key) begin
                k[7:0] = k[7:0] + 8'd1; // Keep the trojan quiet
            end
            expected = cipher_model(pt, k, vec_table[i].mode);
            start = 1'b1;
            plaintext = pt;
            key = k;
            mode = vec_table[i].mode;
            @(posedge clk); // Accepting edge
            @(negedge clk);
            start = 1'b0;
            edges = 0;
            while (!done) begin
                assert (busy) else report_error($sformatf("row %0d busy low mid-run", i));
                assert (ciphertext == held_ct)
                    else report_error($sformatf("row %0d ciphertext moved before done", i));
                if (vec_table[i].extra_start && edges == 20) begin
                    draw_block(pt2);
                    draw_block(k2);
                    start = 1'b1; // Must be ignored
                    plaintext = pt2;
                    key = k2;
                    mode = ~vec_table[i].mode;
                end else begin
                    start = 1'b0;
                end
                @(posedge clk);
                edges++;
                @(negedge clk);
            end
            assert (edges == vec_table[i].latency)
                else report_error($sformatf("row %0d done after %0d edges", i, edges));
            assert (ciphertext == expected)
                else report_error($sformatf("row %0d ciphertext %h expected %h",
                                            i, ciphertext, expected));
            held_ct = ciphertext;
            repeat (4) begin
                @(negedge clk);
                assert (!done && !busy && ciphertext == held_ct)
                    else report_error($sformatf("row %0d activity after done", i));
            end
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- all.f
+incdir+tests
source/crypto_pkg.sv
source/key_expander.sv
source/sbox_unit.sv
source/trojan9_payload.sv
source/crypto_round_ctrl.sv
source/crypto_host_top.sv
tests/crypto_host_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the cipher testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module crypto_host_tb -f all.f -o crypto_host_sim

./obj_dir/crypto_host_sim | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
